/* Makefile */
VERILATOR ?= verilator
TOP       := serdes_link_tb
FILELIST  := all.f
VFLAGS    := --binary --timing --assert -j 0
BUILD_DIR := obj_dir
LOG       := sim.log
FAIL_MSG  := SIMULATION FAILED
PASS_MSG  := SIMULATION PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "run failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "run ended early"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* all.f */
hw/serdes_pkg.sv
hw/word_pattern_gen.sv
hw/symbol_serializer.sv
hw/comma_aligner.sv
hw/link_checker.sv
hw/serdes_link_top.sv
test/serdes_link_assert.sv
test/serdes_link_tb.sv

/* hw/comma_aligner.sv */
`timescale 1ns/1ps

module comma_aligner (
  input  logic                          tx_pclk,
  input  logic                          rst_n,
  input  logic                          serial_in,
  output logic                          locked,
  output logic                          rx_valid,
  output logic [serdes_pkg::DATA_W-1:0] rx_data,
  output logic                          rx_comma
);
  import serdes_pkg::*;

  logic [2*SYM_BITS-1:0] hist_q;     // current window plus the symbol before it
  logic [2*SYM_BITS-1:0] hist_d;
  logic [SYM_BITS-1:0]   window;
  logic [SYM_BITS-1:0]   prev_sym;
  logic [PHASE_W-1:0]    bit_phase;
  logic [FRAME_W-1:0]    sym_cnt;    // symbols since the last comma
  logic                  is_comma;
  logic                  sym_done;
  logic                  frame_slot;
  logic                  lock_hit;
  logic                  sym_ok;
  logic                  sym_bad;

  // newest bit enters at the top, oldest sits at bit 0
  assign hist_d   = {serial_in, hist_q[2*SYM_BITS-1:1]};
  assign window   = hist_d[2*SYM_BITS-1:SYM_BITS];
  assign prev_sym = hist_d[SYM_BITS-1:0];
  assign is_comma = (window == COMMA_A);

  assign sym_done   = (bit_phase == PHASE_W'(SYM_BITS - 1));
  assign frame_slot = (sym_cnt == FRAME_W'(FRAME_WORDS - 1));

  // search at every bit position while unlocked
  assign lock_hit = !locked && is_comma && (prev_sym == PRE_COMMA);
  // comma exactly at the frame slot and nowhere else
  assign sym_ok   = locked && sym_done && (is_comma == frame_slot);
  assign sym_bad  = locked && sym_done && (is_comma != frame_slot);

  always_ff @(posedge tx_pclk) begin
    if (!rst_n) begin
      hist_q    <= '0;
      locked    <= 1'b0;
      rx_valid  <= 1'b0;
      rx_comma  <= 1'b0;
      bit_phase <= '0;
      sym_cnt   <= '0;
    end else begin
      hist_q   <= hist_d;
      rx_valid <= lock_hit || sym_ok;
      rx_comma <= (lock_hit || sym_ok) && is_comma;

      if (lock_hit) begin
        locked    <= 1'b1;
        bit_phase <= '0;
        sym_cnt   <= '0;
      end else if (sym_bad) begin
        locked    <= 1'b0;  // no rx_valid for the offending symbol
        bit_phase <= '0;
      end else if (sym_ok) begin
        bit_phase <= '0;
        sym_cnt   <= frame_slot ? '0 : sym_cnt + 1'b1;
      end else if (locked) begin
        bit_phase <= bit_phase + 1'b1;
      end
    end
  end

  always_ff @(posedge tx_pclk) begin
    if (lock_hit || sym_ok) begin
      rx_data <= window[DATA_W-1:0];
    end
  end

endmodule

/* hw/link_checker.sv */
`timescale 1ns/1ps

module link_checker (
  input  logic                          tx_pclk,
  input  logic                          rst_n,
  input  logic                          locked,
  input  logic                          rx_valid,
  input  logic [serdes_pkg::DATA_W-1:0] rx_data,
  input  logic                          rx_comma,
  output logic [serdes_pkg::ERR_W-1:0]  error_count
);
  import serdes_pkg::*;

  logic              synced;    // seen a comma since lock
  logic [DATA_W-1:0] expected;
  logic              data_stb;
  logic              mismatch;

  assign data_stb = rx_valid && !rx_comma && synced;
  assign mismatch = data_stb && (rx_data != expected);

  always_ff @(posedge tx_pclk) begin
    if (!rst_n) begin
      synced      <= 1'b0;
      error_count <= '0;
    end else begin
      if (!locked) begin
        synced <= 1'b0;
      end else if (rx_valid && rx_comma) begin
        synced <= 1'b1;
      end

      // saturate at all ones
      if (mismatch && (error_count != '1)) begin
        error_count <= error_count + 1'b1;
      end
    end
  end

  // prediction advances on every data word, good or bad
  always_ff @(posedge tx_pclk) begin
    if (rx_valid && rx_comma) begin
      expected <= DATA_W'(1);
    end else if (data_stb) begin
      expected <= expected + 1'b1;
    end
  end

endmodule

/* hw/serdes_link_top.sv */
`timescale 1ns/1ps

module serdes_link_top (
  input  logic                          tx_pclk,
  input  logic                          rst_n,
  output logic                          serial_out,
  input  logic                          serial_in,
  output logic                          locked,
  output logic                          rx_valid,
  output logic [serdes_pkg::DATA_W-1:0] rx_data,
  output logic                          rx_comma,
  output logic [serdes_pkg::ERR_W-1:0]  error_count
);
  import serdes_pkg::*;

  logic              word_stb;
  logic [DATA_W-1:0] word_data;
  logic              word_comma;

  // transmit chain
  word_pattern_gen u_gen (
    .tx_pclk    (tx_pclk),
    .rst_n      (rst_n),
    .word_stb   (word_stb),
    .word_data  (word_data),
    .word_comma (word_comma)
  );

  symbol_serializer u_ser (
    .tx_pclk    (tx_pclk),
    .rst_n      (rst_n),
    .word_stb   (word_stb),
    .word_data  (word_data),
    .word_comma (word_comma),
    .serial_out (serial_out)
  );

  // receive chain, loopback is outside
  comma_aligner u_align (
    .tx_pclk   (tx_pclk),
    .rst_n     (rst_n),
    .serial_in (serial_in),
    .locked    (locked),
    .rx_valid  (rx_valid),
    .rx_data   (rx_data),
    .rx_comma  (rx_comma)
  );

  link_checker u_check (
    .tx_pclk     (tx_pclk),
    .rst_n       (rst_n),
    .locked      (locked),
    .rx_valid    (rx_valid),
    .rx_data     (rx_data),
    .rx_comma    (rx_comma),
    .error_count (error_count)
  );

endmodule

/* hw/serdes_pkg.sv */
package serdes_pkg;

  // symbol and payload widths
  localparam int SYM_BITS = 10;
  localparam int DATA_W   = 8;
  localparam int PHASE_W  = $clog2(SYM_BITS);  // bit position inside a symbol

  // user-defined comma, bit 9 set so an aligned data symbol never matches
  localparam logic [SYM_BITS-1:0] COMMA_A = 10'h283;

  // one comma slot per frame, data words 1..255 in between
  localparam int FRAME_WORDS = 256;
  localparam int FRAME_W     = $clog2(FRAME_WORDS);

  // Last data word of every frame. The aligner only accepts a comma that
  // follows this symbol, since some data pairs form the comma pattern when
  // read across a symbol boundary.
  localparam logic [SYM_BITS-1:0] PRE_COMMA = SYM_BITS'(FRAME_WORDS - 1);

  // mismatch counter
  localparam int ERR_W = 16;

endpackage

/* hw/symbol_serializer.sv */
`timescale 1ns/1ps

module symbol_serializer (
  input  logic                          tx_pclk,
  input  logic                          rst_n,
  input  logic                          word_stb,
  input  logic [serdes_pkg::DATA_W-1:0] word_data,
  input  logic                          word_comma,
  output logic                          serial_out
);
  import serdes_pkg::*;

  logic [SYM_BITS-1:0] symbol;
  logic [SYM_BITS-1:0] shreg;

  // encoder bypassed, data symbols keep bits 9:8 clear
  assign symbol = word_comma ? COMMA_A : {{(SYM_BITS - DATA_W){1'b0}}, word_data};

  // load on the strobe, then shift right so bit 0 leaves first
  always_ff @(posedge tx_pclk) begin
    if (!rst_n) begin
      shreg <= '0;
    end else if (word_stb) begin
      shreg <= symbol;
    end else begin
      shreg <= {1'b0, shreg[SYM_BITS-1:1]};
    end
  end

  assign serial_out = shreg[0];

endmodule

/* hw/word_pattern_gen.sv */
`timescale 1ns/1ps

module word_pattern_gen (
  input  logic                          tx_pclk,
  input  logic                          rst_n,
  output logic                          word_stb,
  output logic [serdes_pkg::DATA_W-1:0] word_data,
  output logic                          word_comma
);
  import serdes_pkg::*;

  logic [PHASE_W-1:0] phase;
  logic [FRAME_W-1:0] word_cnt;

  // phase runs 0..SYM_BITS-1, one word per lap
  always_ff @(posedge tx_pclk) begin
    if (!rst_n) begin
      phase    <= '0;
      word_cnt <= '0;
    end else begin
      if (phase == PHASE_W'(SYM_BITS - 1)) begin
        phase <= '0;
      end else begin
        phase <= phase + 1'b1;
      end
      if (word_stb) begin
        word_cnt <= word_cnt + 1'b1;  // wraps once per frame
      end
    end
  end

  assign word_stb   = (phase == '0);
  assign word_comma = (word_cnt == '0);      // frame slot
  assign word_data  = word_cnt[DATA_W-1:0];  // don't care on the comma word

endmodule

/* test/serdes_link_assert.sv */
`timescale 1ns/1ps

module serdes_link_assert (
  input logic                         tx_pclk,
  input logic                         rst_n,
  input logic                         locked,
  input logic                         rx_valid,
  input logic                         rx_comma,
  input logic [serdes_pkg::ERR_W-1:0] error_count
);
  import serdes_pkg::*;

  logic [PHASE_W-1:0] gap;  // cycles since the last rx_valid, stops at SYM_BITS

  always_ff @(posedge tx_pclk) begin
    if (!rst_n) begin
      gap <= PHASE_W'(SYM_BITS);
    end else if (rx_valid) begin
      gap <= PHASE_W'(1);
    end else if (gap != PHASE_W'(SYM_BITS)) begin
      gap <= gap + 1'b1;
    end
  end

  valid_needs_lock: assert property (@(posedge tx_pclk) disable iff (!rst_n)
    rx_valid |-> locked)
    else $error("rx_valid while unlocked");

  comma_needs_valid: assert property (@(posedge tx_pclk) disable iff (!rst_n)
    rx_comma |-> rx_valid)
    else $error("rx_comma without rx_valid");

  // at most one symbol per SYM_BITS cycles
  valid_spacing: assert property (@(posedge tx_pclk) disable iff (!rst_n)
    rx_valid |-> gap == PHASE_W'(SYM_BITS))
    else $error("rx_valid pulses closer than one symbol");

  count_monotonic: assert property (@(posedge tx_pclk) disable iff (!rst_n)
    error_count >= $past(error_count))
    else $error("error_count decreased");

endmodule

bind link_checker serdes_link_assert u_check_sva (
  .tx_pclk     (tx_pclk),
  .rst_n       (rst_n),
  .locked      (locked),
  .rx_valid    (rx_valid),
  .rx_comma    (rx_comma),
  .error_count (error_count)
);

/* test/serdes_link_tb.sv */
`timescale 1ns/1ps

module serdes_link_tb;
  import serdes_pkg::*;

  localparam int MAX_DELAY = 20;
  localparam int FRAME_CYC = FRAME_WORDS * SYM_BITS;

  logic              tx_pclk = 1'b0;
  logic              rst_n;
  logic              serial_in;
  logic              serial_out;
  logic              locked;
  logic              rx_valid;
  logic [DATA_W-1:0] rx_data;
  logic              rx_comma;
  logic [ERR_W-1:0]  error_count;

  logic [MAX_DELAY-1:0] line;       // channel delay line, newest bit at 0
  logic [SYM_BITS-1:0]  sent;       // last bits driven into serial_in, newest on top
  int                   delay;
  logic                 cut;        // line held at 0
  int                   flip_at;    // cycles until the inverted bit goes out
  logic [31:0]          rng;
  logic [DATA_W-1:0]    next_word;  // predicted symbol, 0 means the comma slot
  logic [DATA_W-1:0]    flip_mask;
  logic                 synced;
  logic                 locked_q;
  logic                 corrupt_req;
  logic [ERR_W-1:0]     err_model;
  logic [ERR_W-1:0]     err_hold;
  int                   tx_bits;    // rising edges out of reset
  int                   rx_seen;
  int                   gap;

  always #5 tx_pclk = ~tx_pclk;

  serdes_link_top DUT (.*);

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic int rand_below(input int range);
    rng = xorshift32(rng);
    return int'(rng[15:0]) % range;
  endfunction

  // serializer output after the given number of edges out of reset
  function automatic logic tx_bit(input int edges);
    int                  idx;
    logic [SYM_BITS-1:0] sym;
    if (edges == 0) return 1'b0;
    idx = (edges - 1) / SYM_BITS;
    sym = (idx % FRAME_WORDS == 0) ? COMMA_A : SYM_BITS'(idx % FRAME_WORDS);
    return sym[(edges - 1) % SYM_BITS];
  endfunction

  task automatic check_equal(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("error: %s is %h, expected %h", name, got, exp);
      $display("SIMULATION FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic fail_timeout(input string what);
    $display("timeout: gave up waiting for %s", what);
    $display("SIMULATION FAILED");
    $fatal(1, "timeout");
  endtask

  // reference model, runs on the outputs of the last rising edge
  task automatic observe();
    int flip_bit;
    gap++;
    if (rst_n) tx_bits++;
    check_equal("serial_out", 32'(serial_out), 32'(tx_bit(tx_bits)));
    check_equal("error_count", 32'(error_count), 32'(err_model));
    if (rx_comma) check_equal("rx_valid", 32'(rx_valid), 1);
    if (locked && !locked_q) check_equal("rx_valid", 32'(rx_valid), 1);  // lock comes with its comma
    if (!locked && locked_q) check_equal("cycles to locked drop", gap, SYM_BITS);
    if (rx_valid) begin
      rx_seen++;
      check_equal("locked", 32'(locked), 1);
      if (synced) check_equal("rx_valid spacing", gap, SYM_BITS);
      gap = 0;
      if (!synced) begin
        check_equal("rx_comma", 32'(rx_comma), 1);  // lock comes on a comma
      end else if (!cut) begin
        check_equal("rx_comma", 32'(rx_comma), 32'(next_word == '0));
        if (!rx_comma) check_equal("rx_data", 32'(rx_data), 32'(next_word ^ flip_mask));
      end else begin
        check_equal("rx_data", 32'(rx_data), 32'(sent[DATA_W-1:0]));  // zeros after the cut
      end
      if (rx_comma) begin
        next_word = DATA_W'(1);
      end else begin
        if (synced && sent[DATA_W-1:0] != next_word && err_model != '1) begin
          err_model = err_model + 1'b1;
        end
        next_word = next_word + 1'b1;  // 255 wraps to the comma slot
        flip_mask = '0;
      end
      if (corrupt_req && !cut && next_word != '0) begin
        flip_bit    = rand_below(DATA_W);
        flip_mask   = DATA_W'(1) << flip_bit;
        flip_at     = flip_bit;
        corrupt_req = 1'b0;
      end
    end
    if (!locked) begin
      synced = 1'b0;
    end else if (rx_valid && rx_comma) begin
      synced = 1'b1;
    end
    locked_q = locked;
  endtask

  task automatic tick();
    @(negedge tx_pclk);
    observe();
    line = {line[MAX_DELAY-2:0], serial_out};
    serial_in = cut ? 1'b0 : line[delay] ^ (flip_at == 0);
    sent = {serial_in, sent[SYM_BITS-1:1]};
    if (flip_at >= 0) flip_at--;
  endtask

  task automatic wait_locked(input logic level, input int limit, input string what);
    int n;
    n = 0;
    while (locked !== level) begin
      if (n == limit) fail_timeout(what);
      tick();
      n++;
    end
  endtask

  task automatic wait_symbols(input int count);
    int target;
    int n;
    target = rx_seen + count;
    n = 0;
    while (rx_seen < target) begin
      if (n == (count + 2) * SYM_BITS) fail_timeout("received symbols");
      tick();
      n++;
    end
  endtask

  // invert one data bit of the next data symbol on the line
  task automatic corrupt_one();
    int n;
    n = 0;
    corrupt_req = 1'b1;
    while (corrupt_req || flip_mask != '0) begin
      if (n == 4 * SYM_BITS) fail_timeout("the corrupted symbol");
      tick();
      n++;
    end
  endtask

  initial begin
    rst_n = 1'b0;
    serial_in = 1'b0;
    cut = 1'b0;
    line = '0;
    sent = '0;
    flip_at = -1;
    rng = 32'h88c5;
    next_word = '0;
    flip_mask = '0;
    synced = 1'b0;
    locked_q = 1'b0;
    corrupt_req = 1'b0;
    err_model = '0;
    err_hold = '0;
    tx_bits = 0;
    rx_seen = 0;
    gap = 0;
    delay = rand_below(MAX_DELAY);

    for (int i = 0; i < 4; i++) begin
      tick();
      check_equal("locked", 32'(locked), 0);
      check_equal("rx_valid", 32'(rx_valid), 0);
      check_equal("rx_comma", 32'(rx_comma), 0);
      check_equal("error_count", 32'(error_count), 0);
      if (i == 2) rst_n = 1'b1;  // low for 3 rising edges
    end

    for (int round = 0; round < 4; round++) begin
      if (round > 0) begin
        cut = 1'b1;
        wait_locked(1'b0, FRAME_CYC + 2 * SYM_BITS, "loss of lock after the cut");
        err_hold = error_count;
        repeat (3 * SYM_BITS) tick();
        delay = rand_below(MAX_DELAY);
        cut = 1'b0;
      end
      wait_locked(1'b1, 600 * SYM_BITS, "lock");
      wait_symbols(FRAME_WORDS + 20);
      if (round > 0) check_equal("error_count", 32'(error_count), 32'(err_hold));
      if (round % 2 == 1) begin
        err_hold = error_count;
        repeat (4) begin
          corrupt_one();
          wait_symbols(1 + rand_below(5));
        end
        check_equal("error_count", 32'(error_count), 32'(err_hold) + 4);
      end
    end

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule
